// File: fmap_pkg.sv
package fmap_pkg;

	// One feature word as stored in either bank.
	typedef logic [15:0] feat_t;

	// Bank address wide enough for the full feature map.
	typedef logic [14:0] addr_t;

	// Write request to a bank. Data lands at addr on the edge where wen is high.
	typedef struct packed {
		logic  wen;
		addr_t addr;
		feat_t data;
	} wr_req_t;

	// The streamed output pair, one word from each bank at the same address.
	typedef struct packed {
		feat_t feature_0;
		feat_t feature_1;
	} feat_pair_t;

	// Source of the words written into bank 1.
	typedef enum logic {
		SRC_POOL    = 1'b0,
		SRC_ELTWISE = 1'b1
	} src_sel_t;

	// Cycles from a read address at a bank input to its word at the bank output.
	localparam int BANK_LATENCY = 3;

endpackage

// File: dual_port_ram.sv
`timescale 1ns/1ns

module dual_port_ram #(
	parameter int DATA_WIDTH = 16,
	parameter int ADDR_WIDTH = 15
) (
	input  logic                  clk,

	// Write port.
	input  logic                  i_wen,
	input  logic [ADDR_WIDTH-1:0] i_waddr,
	input  logic [DATA_WIDTH-1:0] i_wdata,

	// Read port with one cycle from address to data.
	input  logic [ADDR_WIDTH-1:0] i_raddr,
	output logic [DATA_WIDTH-1:0] o_rdata
);

	localparam int DEPTH = 2 ** ADDR_WIDTH;

	logic [DATA_WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (i_wen) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// A read of the address being written returns the old word.
	always_ff @(posedge clk) begin
		o_rdata <= mem[i_raddr];
	end

endmodule

// File: feature_bank.sv
`timescale 1ns/1ns

module feature_bank (
	input  logic              clk,

	// Write side, loaded before a sweep.
	input  fmap_pkg::wr_req_t i_wr,

	// Read side, driven by the sweep address.
	input  fmap_pkg::addr_t   i_raddr,
	output fmap_pkg::feat_t   o_rdata
);

	import fmap_pkg::*;

	addr_t raddr_q;
	feat_t ram_rdata;
	feat_t rdata_q;

	// First stage registers the read address so the RAM sees a clean input.
	always_ff @(posedge clk) begin
		raddr_q <= i_raddr;
	end

	// Second stage is the RAM's own registered read.
	dual_port_ram #(
		.DATA_WIDTH ($bits(feat_t)),
		.ADDR_WIDTH ($bits(addr_t))
	) ram_i (
		.clk     (clk),
		.i_wen   (i_wr.wen),
		.i_waddr (i_wr.addr),
		.i_wdata (i_wr.data),
		.i_raddr (raddr_q),
		.o_rdata (ram_rdata)
	);

	// Third stage is the output register, which decouples the RAM from
	// whatever consumes the stream.
	always_ff @(posedge clk) begin
		rdata_q <= ram_rdata;
	end

	assign o_rdata = rdata_q;

endmodule

// File: window_addr_gen.sv
`timescale 1ns/1ns

module window_addr_gen #(
	parameter int TAPS       = 3,
	parameter int TAP_STRIDE = 2,
	parameter int CHANNELS   = 2,
	parameter int ROW_STEP   = 5,
	parameter int POSITIONS  = 1444
) (
	input  logic            clk,
	input  logic            i_reset,
	input  logic            i_start,
	output fmap_pkg::addr_t o_addr,
	output logic            o_valid,
	output logic            o_last
);

	import fmap_pkg::*;

	localparam int TAP_W  = (TAPS > 1) ? $clog2(TAPS) : 1;
	localparam int CHAN_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;
	localparam int POS_W  = (POSITIONS > 1) ? $clog2(POSITIONS) : 1;

	// Base advance when moving to the next position. The channel steps already
	// added CHANNELS-1 to the base, so they are taken back out here.
	localparam addr_t POS_STEP = addr_t'(ROW_STEP - (CHANNELS - 1));
	localparam addr_t TAP_STEP = addr_t'(TAP_STRIDE);

	logic              busy;
	logic [TAP_W-1:0]  tap_cnt;
	logic [CHAN_W-1:0] chan_cnt;
	logic [POS_W-1:0]  pos_cnt;
	addr_t             base;
	addr_t             offset;

	logic tap_last;
	logic chan_last;
	logic pos_last;
	logic sweep_last;

	assign tap_last   = (tap_cnt == TAP_W'(TAPS - 1));
	assign chan_last  = (chan_cnt == CHAN_W'(CHANNELS - 1));
	assign pos_last   = (pos_cnt == POS_W'(POSITIONS - 1));
	assign sweep_last = tap_last && chan_last && pos_last;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			busy     <= 1'b0;
			tap_cnt  <= '0;
			chan_cnt <= '0;
			pos_cnt  <= '0;
			base     <= '0;
			offset   <= '0;
		end else if (!busy) begin
			// A start strobe while busy falls through to the sweep branch and is lost.
			if (i_start) begin
				busy <= 1'b1;
			end
		end else if (sweep_last) begin
			busy     <= 1'b0;
			tap_cnt  <= '0;
			chan_cnt <= '0;
			pos_cnt  <= '0;
			base     <= '0;
			offset   <= '0;
		end else if (tap_last) begin
			tap_cnt <= '0;
			offset  <= '0;
			if (chan_last) begin
				chan_cnt <= '0;
				pos_cnt  <= pos_cnt + 1'b1;
				base     <= base + POS_STEP;
			end else begin
				chan_cnt <= chan_cnt + 1'b1;
				base     <= base + addr_t'(1);
			end
		end else begin
			tap_cnt <= tap_cnt + 1'b1;
			offset  <= offset + TAP_STEP;
		end
	end

	// base holds position*ROW_STEP + channel and offset holds tap*TAP_STRIDE.
	assign o_addr  = base + offset;
	assign o_valid = busy;
	assign o_last  = busy && sweep_last;

endmodule

// File: stream_buffer.sv
`timescale 1ns/1ns

module stream_buffer #(
	parameter int TAPS       = 3,
	parameter int TAP_STRIDE = 2,
	parameter int CHANNELS   = 2,
	parameter int ROW_STEP   = 5,
	parameter int POSITIONS  = 1444
) (
	input  logic                 clk,
	input  logic                 i_reset,
	input  logic                 i_start,

	// Bank 0 load from external memory.
	input  fmap_pkg::wr_req_t    i_wr0,

	// Bank 1 write back from the pooling or element-wise stage.
	input  logic                 i_wr1_en,
	input  fmap_pkg::addr_t      i_wr1_addr,
	input  fmap_pkg::feat_t      i_pool,
	input  fmap_pkg::feat_t      i_eltwise,
	input  logic                 i_eltwise_sel,

	// Output stream.
	output fmap_pkg::feat_pair_t o_features,
	output logic                 o_valid,
	output logic                 o_done
);

	import fmap_pkg::*;

	addr_t   sweep_addr;
	logic    sweep_valid;
	logic    sweep_last;
	wr_req_t wr1;
	feat_t   bank0_rdata;
	feat_t   bank1_rdata;

	logic [BANK_LATENCY-1:0] valid_sr;
	logic [BANK_LATENCY-1:0] last_sr;

	window_addr_gen #(
		.TAPS       (TAPS),
		.TAP_STRIDE (TAP_STRIDE),
		.CHANNELS   (CHANNELS),
		.ROW_STEP   (ROW_STEP),
		.POSITIONS  (POSITIONS)
	) addr_gen_i (
		.clk     (clk),
		.i_reset (i_reset),
		.i_start (i_start),
		.o_addr  (sweep_addr),
		.o_valid (sweep_valid),
		.o_last  (sweep_last)
	);

	// Bank 1 takes its data from one of the two result stages.
	always_comb begin
		wr1.wen  = i_wr1_en;
		wr1.addr = i_wr1_addr;
		if (src_sel_t'(i_eltwise_sel) == SRC_ELTWISE) begin
			wr1.data = i_eltwise;
		end else begin
			wr1.data = i_pool;
		end
	end

	feature_bank bank0_i (
		.clk     (clk),
		.i_wr    (i_wr0),
		.i_raddr (sweep_addr),
		.o_rdata (bank0_rdata)
	);

	feature_bank bank1_i (
		.clk     (clk),
		.i_wr    (wr1),
		.i_raddr (sweep_addr),
		.o_rdata (bank1_rdata)
	);

	// The strobes follow the address through the same number of stages as
	// the bank data, so they line up with the words at the bank outputs.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			valid_sr <= '0;
			last_sr  <= '0;
		end else begin
			valid_sr <= {valid_sr[BANK_LATENCY-2:0], sweep_valid};
			last_sr  <= {last_sr[BANK_LATENCY-2:0], sweep_last};
		end
	end

	always_comb begin
		o_features.feature_0 = bank0_rdata;
		o_features.feature_1 = bank1_rdata;
	end

	assign o_valid = valid_sr[BANK_LATENCY-1];
	assign o_done  = last_sr[BANK_LATENCY-1];

endmodule

// File: stream_buffer_assertions.sv
`timescale 1ns/1ns

module stream_buffer_assertions (
	input logic clk,
	input logic i_reset,
	input logic o_valid,
	input logic o_done
);

	import fmap_pkg::*;

	int fail_count = 0;

	// The done strobe always marks a valid word.
	done_with_valid: assert property (@(posedge clk) disable iff (i_reset) o_done |-> o_valid)
	else begin
		fail_count++;
		$error("o_done is high while o_valid is low");
	end

	// Done is a single-cycle pulse.
	done_single: assert property (@(posedge clk) disable iff (i_reset) o_done |=> !o_done)
	else begin
		fail_count++;
		$error("o_done is high for two cycles in a row");
	end

	// The delay line is empty when reset ends, so nothing can come out for a while.
	valid_after_reset: assert property (@(posedge clk) $fell(i_reset) |-> !o_valid [*BANK_LATENCY])
	else begin
		fail_count++;
		$error("o_valid is high right after reset");
	end

endmodule

bind stream_buffer stream_buffer_assertions assertions_i (
	.clk     (clk),
	.i_reset (i_reset),
	.o_valid (o_valid),
	.o_done  (o_done)
);

// File: tb_stream_buffer.sv
`timescale 1ns/1ns

module tb_stream_buffer;

	import fmap_pkg::*;

	localparam int TAPS        = 3;
	localparam int TAP_STRIDE  = 2;
	localparam int CHANNELS    = 2;
	localparam int ROW_STEP    = 5;
	localparam int POSITIONS   = 4;
	localparam int SWEEP_LEN   = POSITIONS * CHANNELS * TAPS;
	localparam int MODEL_DEPTH = 64;
	localparam int TIMEOUT     = 100;

	logic       clk;
	logic       i_reset;
	logic       i_start;
	wr_req_t    i_wr0;
	logic       i_wr1_en;
	addr_t      i_wr1_addr;
	feat_t      i_pool;
	feat_t      i_eltwise;
	logic       i_eltwise_sel;
	feat_pair_t o_features;
	logic       o_valid;
	logic       o_done;

	logic [31:0] lcg_state;
	addr_t       sweep_addrs [SWEEP_LEN];
	feat_t       bank0_model [MODEL_DEPTH];
	feat_t       bank1_model [MODEL_DEPTH];
	feat_pair_t  got_pairs [$];
	int          done_count;
	int          done_index;
	int          start_latency;

	stream_buffer #(
		.TAPS       (TAPS),
		.TAP_STRIDE (TAP_STRIDE),
		.CHANNELS   (CHANNELS),
		.ROW_STEP   (ROW_STEP),
		.POSITIONS  (POSITIONS)
	) stream_buffer_i (
		.clk           (clk),
		.i_reset       (i_reset),
		.i_start       (i_start),
		.i_wr0         (i_wr0),
		.i_wr1_en      (i_wr1_en),
		.i_wr1_addr    (i_wr1_addr),
		.i_pool        (i_pool),
		.i_eltwise     (i_eltwise),
		.i_eltwise_sel (i_eltwise_sel),
		.o_features    (o_features),
		.o_valid       (o_valid),
		.o_done        (o_done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(negedge clk) begin
		if (stream_buffer_i.assertions_i.fail_count != 0) begin
			$display("A bound assertion on the output strobes failed");
			$display("RESULT: FAIL");
			$fatal(1, "assertion failure");
		end
	end

	function automatic feat_t next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	task automatic check_value(input string test_name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected=%0h actual=%0h", test_name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	endtask

	// The tap address is position*ROW_STEP + channel + tap*TAP_STRIDE. Taps are innermost.
	task automatic build_sweep_addrs();
		int idx;
		idx = 0;
		for (int pos = 0; pos < POSITIONS; pos++) begin
			for (int ch = 0; ch < CHANNELS; ch++) begin
				for (int tap = 0; tap < TAPS; tap++) begin
					sweep_addrs[idx] = addr_t'(pos * ROW_STEP + ch + tap * TAP_STRIDE);
					idx++;
				end
			end
		end
	endtask

	task automatic write_bank0(input addr_t addr, input feat_t data);
		@(negedge clk);
		i_wr0 = '{wen: 1'b1, addr: addr, data: data};
		@(negedge clk);
		i_wr0.wen = 1'b0;
	endtask

	task automatic write_bank1(input addr_t addr, input feat_t pool, input feat_t eltwise,
			input logic sel);
		@(negedge clk);
		i_wr1_en      = 1'b1;
		i_wr1_addr    = addr;
		i_pool        = pool;
		i_eltwise     = eltwise;
		i_eltwise_sel = sel;
		@(negedge clk);
		i_wr1_en = 1'b0;
	endtask

	// Pulses start, then collects every valid pair. A second start goes in at
	// output index restart_at when that is not negative.
	task automatic run_sweep(input string test_name, input int restart_at);
		int wait_cycles;
		int idx;
		got_pairs.delete();
		done_count = 0;
		done_index = -1;
		@(negedge clk);
		i_start = 1'b1;
		@(negedge clk);
		i_start = 1'b0;
		wait_cycles = 1;
		while (!o_valid) begin
			if (wait_cycles >= TIMEOUT) begin
				stop_on_timeout({test_name, " first o_valid"});
			end
			@(negedge clk);
			wait_cycles++;
		end
		start_latency = wait_cycles;
		idx = 0;
		while (o_valid) begin
			if (idx >= TIMEOUT) begin
				stop_on_timeout({test_name, " end of o_valid"});
			end
			got_pairs.push_back(o_features);
			if (o_done) begin
				done_count++;
				done_index = idx;
			end
			i_start = (idx == restart_at);
			@(negedge clk);
			idx++;
		end
		i_start = 1'b0;
	endtask

	task automatic check_sweep(input string test_name, input bit with_bank1);
		check_value({test_name, " count"}, SWEEP_LEN, got_pairs.size());
		for (int i = 0; i < SWEEP_LEN; i++) begin
			check_value({test_name, " feature_0"}, bank0_model[sweep_addrs[i]],
				got_pairs[i].feature_0);
			if (with_bank1) begin
				check_value({test_name, " feature_1"}, bank1_model[sweep_addrs[i]],
					got_pairs[i].feature_1);
			end
		end
	endtask

	task automatic test_reset_state();
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			check_value("reset_state in reset", 0, {o_valid, o_done});
		end
		i_reset = 1'b0;
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			check_value("reset_state idle", 0, {o_valid, o_done});
		end
	endtask

	task automatic test_bank0_order();
		// Repeated addresses keep the last word written, as the bank does.
		for (int i = 0; i < SWEEP_LEN; i++) begin
			bank0_model[sweep_addrs[i]] = next_random();
			write_bank0(sweep_addrs[i], bank0_model[sweep_addrs[i]]);
		end
		run_sweep("bank0_order", -1);
		check_sweep("bank0_order", 1'b0);
	endtask

	task automatic test_bank1_select();
		bit    seen [MODEL_DEPTH];
		addr_t uniq [$];
		feat_t chosen;
		feat_t other;
		int    half;
		for (int i = 0; i < SWEEP_LEN; i++) begin
			if (!seen[sweep_addrs[i]]) begin
				seen[sweep_addrs[i]] = 1'b1;
				uniq.push_back(sweep_addrs[i]);
			end
		end
		half = uniq.size() / 2;
		for (int i = 0; i < uniq.size(); i++) begin
			chosen = next_random();
			other  = next_random();
			if (other == chosen) begin
				other = ~chosen;
			end
			bank1_model[uniq[i]] = chosen;
			if (i < half) begin
				write_bank1(uniq[i], chosen, other, 1'b0);
			end else begin
				write_bank1(uniq[i], other, chosen, 1'b1);
			end
		end
		run_sweep("bank1_select", -1);
		check_sweep("bank1_select", 1'b1);
	endtask

	task automatic test_done_latency();
		run_sweep("done_latency", -1);
		check_value("done_latency start to valid", 4, start_latency);
		check_value("done_latency done count", 1, done_count);
		check_value("done_latency done index", SWEEP_LEN - 1, done_index);
	endtask

	task automatic test_restart();
		run_sweep("restart mid sweep", 10);
		check_sweep("restart mid sweep", 1'b1);
		check_value("restart mid sweep done count", 1, done_count);
		run_sweep("restart after done", -1);
		check_sweep("restart after done", 1'b1);
		check_value("restart after done done count", 1, done_count);
	endtask

	initial begin
		lcg_state     = 32'hec46_adb5;
		i_reset       = 1'b1;
		i_start       = 1'b0;
		i_wr0         = '0;
		i_wr1_en      = 1'b0;
		i_wr1_addr    = '0;
		i_pool        = '0;
		i_eltwise     = '0;
		i_eltwise_sel = 1'b0;
		build_sweep_addrs();
		test_reset_state();
		test_bank0_order();
		test_bank1_select();
		test_done_latency();
		test_restart();
		repeat (4) @(negedge clk);
		if (stream_buffer_i.assertions_i.fail_count == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("Bound assertions failed %0d times",
				stream_buffer_i.assertions_i.fail_count);
			$display("RESULT: FAIL");
			$fatal(1, "assertion failure");
		end
	end

endmodule

// File: list.f
fmap_pkg.sv
dual_port_ram.sv
feature_bank.sv
window_addr_gen.sv
stream_buffer.sv
stream_buffer_assertions.sv
tb_stream_buffer.sv
